//--- board_monitor.sv
module board_monitor (
    input  logic                    clk,
    input  logic                    reset,
    placement_if.monitor            place,
    input  tetris_pkg::board_t      board,
    input  logic [4:0]              rows_cleared,
    output logic                    blocked,
    output tetris_pkg::line_count_t lines
);

    logic [15:0] hit; // Per mask cell collision

    // A set mask cell hits when off field or over a stored cell
    always_comb
    begin : overlap
        logic [5:0] r;
        logic [4:0] c;

        hit = '0;
        for (int k = 0; k < 16; k++)
        begin
            r = {1'b0, place.row} + 6'(k / 4);
            c = {1'b0, place.col} + 5'(k % 4);
            if (place.mask[k])
            begin
                if (!place.on_field
                    || (c >= 5'(tetris_pkg::field_cols))
                    || (r >= 6'(tetris_pkg::field_rows)))
                    hit[k] = 1'b1;
                else
                    hit[k] = board[r * tetris_pkg::field_cols + c];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            blocked <= 1'b0;
        else
            blocked <= |hit;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            lines <= '0;
        else
            lines <= lines + tetris_pkg::line_count_t'(rows_cleared); // Wraps
    end

    a_rows_bound: assert property (
        @(posedge clk) disable iff (reset)
        rows_cleared <= 5'(tetris_pkg::field_rows)
    ) else $error("more rows cleared than the field holds");

endmodule

//--- board_store.sv
module board_store (
    input  logic               clk,
    input  logic               reset,
    placement_if.store         place,
    output tetris_pkg::board_t board,
    output logic [4:0]         rows_cleared
);

    tetris_pkg::board_t                   piece_bits;  // Cells set by a lock
    tetris_pkg::board_t                   clear_mask;  // Cells of full rows
    logic [tetris_pkg::field_rows-1:0]    full_rows;
    logic [4:0]                           full_count;

    // Map the 4x4 mask onto board bits, dropping cells past the field edge
    always_comb
    begin : lock_cells
        logic [5:0] r;
        logic [4:0] c;

        piece_bits = '0;
        for (int k = 0; k < 16; k++)
        begin
            r = {1'b0, place.row} + 6'(k / 4);
            c = {1'b0, place.col} + 5'(k % 4);
            if (place.on_field && place.mask[k]
                && (c < 5'(tetris_pkg::field_cols))
                && (r < 6'(tetris_pkg::field_rows)))
            begin
                piece_bits[r * tetris_pkg::field_cols + c] = 1'b1;
            end
        end
    end

    always_comb
    begin : row_scan
        full_count = '0;
        for (int r = 0; r < tetris_pkg::field_rows; r++)
        begin
            full_rows[r] = &board[r * tetris_pkg::field_cols +: tetris_pkg::field_cols];
            clear_mask[r * tetris_pkg::field_cols +: tetris_pkg::field_cols] =
                {tetris_pkg::field_cols{full_rows[r]}};
            full_count = full_count + 5'(full_rows[r]);
        end
    end

    // Clearing only happens on cycles without a lock
    assign rows_cleared = place.lock ? 5'd0 : full_count;

    always_ff @(posedge clk)
    begin
        if (reset)
            board <= '0;
        else if (place.lock)
            board <= board | piece_bits; // Never clears on a lock
        else
            board <= board & ~clear_mask; // Rows above stay put
    end

    a_no_clear_on_lock: assert property (
        @(posedge clk) disable iff (reset)
        place.lock |-> (rows_cleared == 5'd0)
    ) else $error("rows cleared during a lock cycle");

endmodule

//--- files.f
+incdir+.
tetris_pkg.sv
placement_if.sv
piece_decoder.sv
board_store.sv
board_monitor.sv
tetris_board_top.sv
tb_tetris_board.sv

//--- piece_decoder.sv
module piece_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  tetris_pkg::piece_id_t piece_id,
    input  tetris_pkg::rotation_t rotation,
    input  tetris_pkg::pixel_t    block_x,
    input  tetris_pkg::pixel_t    block_y,
    input  logic                  lock_req,
    placement_if.decoder          place
);

    tetris_pkg::decode_state_t state, state_next;

    tetris_pkg::pixel_t      x_off;
    tetris_pkg::pixel_t      col_full;
    tetris_pkg::pixel_t      row_full;
    logic                    on_field_next;
    tetris_pkg::piece_mask_t mask_next;

    always_comb
    begin
        mask_next = tetris_pkg::piece_shapes[{piece_id, rotation}];
        x_off     = block_x - tetris_pkg::pixel_t'(tetris_pkg::field_left_px);
        col_full  = x_off / tetris_pkg::pixel_t'(tetris_pkg::cell_px);
        row_full  = block_y / tetris_pkg::pixel_t'(tetris_pkg::cell_px);

        // Left of the field wraps x_off, so test the raw pixel too
        on_field_next = (block_x >= tetris_pkg::pixel_t'(tetris_pkg::field_left_px))
                     && (col_full < tetris_pkg::pixel_t'(tetris_pkg::field_cols))
                     && (row_full < tetris_pkg::pixel_t'(tetris_pkg::field_rows));
    end

    always_comb
    begin
        state_next = state;
        case (state)
            tetris_pkg::idle:
                if (lock_req)
                    state_next = tetris_pkg::hold;
            tetris_pkg::hold:
                if (!lock_req)
                    state_next = tetris_pkg::idle; // Wait for release
            default:
                state_next = tetris_pkg::idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state          <= tetris_pkg::idle;
            place.lock     <= 1'b0;
            place.on_field <= 1'b0;
            place.mask     <= '0;
        end
        else
        begin
            state          <= state_next;
            place.lock     <= (state == tetris_pkg::idle) && lock_req;
            place.on_field <= on_field_next;
            place.mask     <= mask_next;
        end
    end

    // Truncated when off field, on_field covers that case
    always_ff @(posedge clk)
    begin
        place.col <= tetris_pkg::cell_col_t'(col_full);
        place.row <= tetris_pkg::cell_row_t'(row_full);
    end

    a_lock_single: assert property (
        @(posedge clk) disable iff (reset)
        place.lock |=> !place.lock
    ) else $error("lock strobe held for more than one cycle");

endmodule

//--- placement_if.sv
interface placement_if;

    tetris_pkg::piece_mask_t mask;
    tetris_pkg::cell_col_t   col;
    tetris_pkg::cell_row_t   row;
    logic                    on_field; // Low when the pixel position is off the field
    logic                    lock;     // One cycle strobe

    modport decoder (
        output mask, col, row, on_field, lock
    );

    modport store (
        input mask, col, row, on_field, lock
    );

    modport monitor (
        input mask, col, row, on_field
    );

endinterface

//--- tb_board_model.svh
`ifndef TB_BOARD_MODEL_SVH
`define TB_BOARD_MODEL_SVH

// Reference copy of the board and the cleared line total
tetris_pkg::board_t      ref_board;
tetris_pkg::line_count_t ref_lines;

function automatic tetris_pkg::piece_mask_t shape_of(
    input tetris_pkg::piece_id_t pid,
    input tetris_pkg::rotation_t rot
);
    return tetris_pkg::piece_shapes[int'(pid) * 4 + int'(rot)];
endfunction

// Pixel to cell, returns 1 when the anchor lies on the field
function automatic bit map_to_field(
    input int x,
    input int y,
    output int col,
    output int row
);
    row = y / tetris_pkg::cell_px;
    if (x < tetris_pkg::field_left_px)
    begin
        col = 0;
        return 1'b0;
    end
    col = (x - tetris_pkg::field_left_px) / tetris_pkg::cell_px;
    return (col < tetris_pkg::field_cols) && (row < tetris_pkg::field_rows);
endfunction

function automatic void wipe_reference();
    ref_board = '0;
    ref_lines = '0;
endfunction

// OR the piece in, cells past the right or bottom edge are dropped
function automatic void apply_lock(
    input tetris_pkg::piece_id_t pid,
    input tetris_pkg::rotation_t rot,
    input tetris_pkg::pixel_t    x,
    input tetris_pkg::pixel_t    y
);
    tetris_pkg::piece_mask_t m;
    int col;
    int row;
    int r;
    int c;
    bit on;

    m  = shape_of(pid, rot);
    on = map_to_field(int'(x), int'(y), col, row);
    if (!on)
        return;
    for (int k = 0; k < 16; k++)
    begin
        r = row + k / 4;
        c = col + k % 4;
        if (m[k] && c < tetris_pkg::field_cols && r < tetris_pkg::field_rows)
            ref_board[r * tetris_pkg::field_cols + c] = 1'b1;
    end
endfunction

function automatic int clear_full_rows();
    int cleared;
    bit full;

    cleared = 0;
    for (int r = 0; r < tetris_pkg::field_rows; r++)
    begin
        full = 1'b1;
        for (int c = 0; c < tetris_pkg::field_cols; c++)
            if (!ref_board[r * tetris_pkg::field_cols + c])
                full = 1'b0;
        if (full)
        begin
            for (int c = 0; c < tetris_pkg::field_cols; c++)
                ref_board[r * tetris_pkg::field_cols + c] = 1'b0; // Rows above stay
            cleared++;
        end
    end
    ref_lines = ref_lines + tetris_pkg::line_count_t'(cleared);
    return cleared;
endfunction

function automatic bit predict_blocked(
    input tetris_pkg::piece_id_t pid,
    input tetris_pkg::rotation_t rot,
    input tetris_pkg::pixel_t    x,
    input tetris_pkg::pixel_t    y
);
    tetris_pkg::piece_mask_t m;
    int col;
    int row;
    int r;
    int c;
    bit on;

    m  = shape_of(pid, rot);
    on = map_to_field(int'(x), int'(y), col, row);
    for (int k = 0; k < 16; k++)
    begin
        r = row + k / 4;
        c = col + k % 4;
        if (m[k])
        begin
            if (!on || c >= tetris_pkg::field_cols || r >= tetris_pkg::field_rows)
                return 1'b1;
            if (ref_board[r * tetris_pkg::field_cols + c])
                return 1'b1;
        end
    end
    return 1'b0;
endfunction

`endif

//--- tb_tetris_board.sv
module tb_tetris_board;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int settle_limit  = 12;
    localparam int lock_count    = 40;
    localparam int probe_count   = 60;
    localparam int long_run_ops  = 300;

    logic                    clk;
    logic                    reset;
    tetris_pkg::piece_id_t   piece_id;
    tetris_pkg::rotation_t   rotation;
    tetris_pkg::pixel_t      block_x;
    tetris_pkg::pixel_t      block_y;
    logic                    lock_req;
    tetris_pkg::board_t      board;
    logic                    blocked;
    tetris_pkg::line_count_t lines;

    logic exp_blocked;
    int   error_count;
    int   check_count;
    int   test_count;
    int   failed_tests;
    int   errors_at_start;

    `include "tb_board_model.svh"

    tetris_board_top uut (
        .clk      (clk),
        .reset    (reset),
        .piece_id (piece_id),
        .rotation (rotation),
        .block_x  (block_x),
        .block_y  (block_y),
        .lock_req (lock_req),
        .board    (board),
        .blocked  (blocked),
        .lines    (lines)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_board(input string what, input tetris_pkg::board_t got,
                               input tetris_pkg::board_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t: %s board got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_blocked(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t: %s blocked got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_lines(input string what, input tetris_pkg::line_count_t got,
                               input tetris_pkg::line_count_t exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t: %s lines got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_piece(input tetris_pkg::piece_id_t pid, input tetris_pkg::rotation_t rot,
                               input int x, input int y);
        piece_id = pid;
        rotation = rot;
        block_x  = tetris_pkg::pixel_t'(x);
        block_y  = tetris_pkg::pixel_t'(y);
    endtask

    // Any of the seven shapes, anchored somewhere on the field
    task automatic place_random();
        drive_piece(tetris_pkg::piece_id_t'($urandom_range(0, 6)),
                    tetris_pkg::rotation_t'($urandom_range(0, 3)),
                    80 + $urandom_range(0, 199), $urandom_range(0, 479));
    endtask

    task automatic pulse_reset();
        reset    = 1'b1;
        lock_req = 1'b0;
        drive_piece(3'd7, 2'd0, 80, 0);
        for (int i = 0; i < 2; i++)
            @(negedge clk);
        reset = 1'b0;
        wipe_reference();
        exp_blocked = 1'b0;
    endtask

    // Raise lock_req, keep it up while the piece moves, then drop it
    task automatic lock_piece(input int hold_cycles);
        lock_req = 1'b1;
        apply_lock(piece_id, rotation, block_x, block_y);
        void'(clear_full_rows());
        for (int i = 0; i < hold_cycles; i++)
        begin
            @(negedge clk);
            if (i < hold_cycles - 1)
                place_random(); // Must not lock again
        end
        lock_req    = 1'b0;
        exp_blocked = predict_blocked(piece_id, rotation, block_x, block_y);
    endtask

    task automatic settle(input string what, input int min_edges);
        int  n;
        bit  done;

        n    = 0;
        done = 1'b0;
        while (!done && n < settle_limit)
        begin
            @(negedge clk);
            n++;
            if (n >= min_edges && board === ref_board && lines === ref_lines
                && blocked === exp_blocked)
                done = 1'b1;
        end
        if (!done)
        begin
            error_count++;
            $display("Timeout: %s did not settle within %0d cycles", what, settle_limit);
        end
        check_board(what, board, ref_board);
        check_blocked(what, blocked, exp_blocked);
        check_lines(what, lines, ref_lines);
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_at_start)
            $display("Test %s: ok", name);
        else
        begin
            failed_tests++;
            $display("Test %s: failed with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    initial
    begin
        tetris_pkg::line_count_t lines_before;

        reset        = 1'b1;
        lock_req     = 1'b0;
        piece_id     = 3'd7;
        rotation     = 2'd0;
        block_x      = 10'd80;
        block_y      = 10'd0;
        exp_blocked  = 1'b0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        void'($urandom(32'h8b1c_b8ad));

        start_test();
        pulse_reset();
        settle("reset", 1);
        finish_test("reset");

        start_test();
        for (int i = 0; i < lock_count; i++)
        begin
            place_random();
            lock_piece(1);
            settle("lock", 2);
        end
        finish_test("lock");

        // Uses the board left behind by the lock test
        start_test();
        for (int i = 0; i < probe_count; i++)
        begin
            drive_piece(tetris_pkg::piece_id_t'($urandom_range(0, 7)),
                        tetris_pkg::rotation_t'($urandom_range(0, 3)),
                        (i % 5 == 0) ? $urandom_range(0, 79) : $urandom_range(0, 300),
                        $urandom_range(0, 500));
            exp_blocked = predict_blocked(piece_id, rotation, block_x, block_y);
            settle("collision", 2);
        end
        finish_test("collision");

        start_test();
        pulse_reset();
        drive_piece(3'd1, 2'd0, 140, 200); // Bystander O at rows 10 and 11
        lock_piece(1);
        settle("row clear setup", 2);
        lines_before = ref_lines;
        for (int c = 0; c < 12; c += 4)
        begin
            drive_piece(3'd0, 2'd0, 80 + c * 20, 460); // Flat I, last one clipped
            lock_piece(1);
            settle("flat fill", 2);
        end
        check_lines("single row", lines, lines_before + 16'd1);
        lines_before = ref_lines;
        for (int c = 0; c < 10; c++)
        begin
            drive_piece(3'd0, 2'd1, 80 + c * 20, 380); // Upright I over rows 19 to 22
            lock_piece(1);
            settle("upright fill", 2);
        end
        check_lines("four rows", lines, lines_before + 16'd4);
        finish_test("row clearing");

        start_test();
        pulse_reset();
        for (int i = 0; i < long_run_ops; i++)
        begin
            place_random();
            if ($urandom_range(0, 2) != 0)
            begin
                lock_piece($urandom_range(1, 4));
                settle("long run lock", 2);
            end
            else
            begin
                exp_blocked = predict_blocked(piece_id, rotation, block_x, block_y);
                settle("long run idle", 2);
            end
        end
        finish_test("long run");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tetris_board_top.sv
module tetris_board_top (
    input  logic                    clk,
    input  logic                    reset,
    input  tetris_pkg::piece_id_t   piece_id,
    input  tetris_pkg::rotation_t   rotation,
    input  tetris_pkg::pixel_t      block_x,
    input  tetris_pkg::pixel_t      block_y,
    input  logic                    lock_req,   // Level, one write per rise
    output tetris_pkg::board_t      board,
    output logic                    blocked,
    output tetris_pkg::line_count_t lines
);

    placement_if place ();

    logic [4:0] rows_cleared;

    piece_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .piece_id (piece_id),
        .rotation (rotation),
        .block_x  (block_x),
        .block_y  (block_y),
        .lock_req (lock_req),
        .place    (place)
    );

    board_store u_store (
        .clk          (clk),
        .reset        (reset),
        .place        (place),
        .board        (board),
        .rows_cleared (rows_cleared)
    );

    board_monitor u_monitor (
        .clk          (clk),
        .reset        (reset),
        .place        (place),
        .board        (board),
        .rows_cleared (rows_cleared),
        .blocked      (blocked),
        .lines        (lines)
    );

endmodule

//--- tetris_pkg.sv
package tetris_pkg;

    localparam int field_cols    = 10;
    localparam int field_rows    = 24;
    localparam int field_cells   = field_cols * field_rows; // 240 board bits
    localparam int cell_px       = 20;
    localparam int field_left_px = 80;

    typedef logic [9:0]             pixel_t;
    typedef logic [3:0]             cell_col_t;
    typedef logic [4:0]             cell_row_t;
    typedef logic [15:0]            piece_mask_t;  // Bit k is row k/4, column k%4
    typedef logic [2:0]             piece_id_t;    // 0..6 I O T S Z J L, 7 empty
    typedef logic [1:0]             rotation_t;    // Quarter turns clockwise
    typedef logic [field_cells-1:0] board_t;       // Cell (r, c) is bit r*10 + c
    typedef logic [15:0]            line_count_t;

    // Indexed by piece type * 4 + rotation, shapes packed to the top-left
    // Hex digit order is row 3 .. row 0, low bit of a digit is column 0
    localparam piece_mask_t piece_shapes [32] = '{
        16'h000F, 16'h1111, 16'h000F, 16'h1111, // I
        16'h0033, 16'h0033, 16'h0033, 16'h0033, // O
        16'h0072, 16'h0131, 16'h0027, 16'h0232, // T
        16'h0036, 16'h0231, 16'h0036, 16'h0231, // S
        16'h0063, 16'h0132, 16'h0063, 16'h0132, // Z
        16'h0071, 16'h0113, 16'h0047, 16'h0322, // J
        16'h0074, 16'h0311, 16'h0017, 16'h0223, // L
        16'h0000, 16'h0000, 16'h0000, 16'h0000  // Empty
    };

    // Lock request edge detect in the decoder
    typedef enum logic {
        idle,
        hold
    } decode_state_t;

endpackage
